//--- verilog/lcd_pkg.sv
package lcd_pkg;

	// clock and LCD timing, all in microseconds except clk_per_us
	localparam int clk_per_us = 40;         // 40 MHz system clock
	localparam int power_up_us = 500;       // wait before first init step
	localparam int setup_us = 1;            // rs/rw/data settle before e
	localparam int pulse_us = 13;           // e high time per command
	localparam int cycle_us = 50;           // full command slot
	localparam int init_pulse_us = 10;      // e high time per init step

	// gap after function set, display control, clear, entry mode
	localparam int init_gap_us [4] = '{50, 50, 200, 100};

	localparam int cnt_bits = 15;           // holds 500 us at 40 MHz

	localparam int fifo_depth = 4;
	localparam int fifo_level_bits = 3;     // 0 to fifo_depth

	// APB byte addresses
	localparam logic [3:0] addr_config = 4'h0;
	localparam logic [3:0] addr_cmd = 4'h4;
	localparam logic [3:0] addr_status = 4'h8;

	typedef struct packed {
		logic two_lines;
		logic font_5x10;
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;
		logic shift;
	} lcd_cfg_t;

	typedef struct packed {
		logic rs;
		logic rw;
		logic [7:0] data;
	} lcd_cmd_t;

	typedef struct packed {
		logic [fifo_level_bits-1:0] level;
		logic full;
		logic busy;
		logic init_done;
	} lcd_status_t;

endpackage

//--- verilog/lcd_cmd_fifo.sv
`timescale 1ns/1ps

module lcd_cmd_fifo (
	input logic clk,
	input logic rst_n,
	input logic push,
	input lcd_pkg::lcd_cmd_t push_cmd,
	input logic pop,
	output lcd_pkg::lcd_cmd_t head,
	output logic empty,
	output logic full,
	output logic [lcd_pkg::fifo_level_bits-1:0] level
);

	typedef logic [$clog2(lcd_pkg::fifo_depth)-1:0] ptr_t;
	typedef logic [lcd_pkg::fifo_level_bits-1:0] level_t;

	lcd_pkg::lcd_cmd_t mem [lcd_pkg::fifo_depth];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	level_t count;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	assign empty = (count == '0);
	assign full = (count == level_t'(lcd_pkg::fifo_depth));
	assign level = count;
	assign head = mem[rd_ptr];  // oldest entry, valid when not empty

	// payload storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // none or both
			endcase
		end
	end

endmodule

//--- verilog/lcd_apb_regs.sv
`timescale 1ns/1ps

module lcd_apb_regs (
	input logic clk,
	input logic rst_n,
	input logic [3:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output lcd_pkg::lcd_cfg_t cfg,
	output logic push,
	output lcd_pkg::lcd_cmd_t push_cmd,
	input logic [lcd_pkg::fifo_level_bits-1:0] level,
	input logic full,
	input logic busy,
	input logic init_done
);

	logic setup_ph;
	logic access_ph;
	logic sel_config;
	logic sel_cmd;
	logic sel_status;
	logic mapped;
	logic overflow;
	lcd_pkg::lcd_status_t status;
	logic [31:0] rd_mux;

	assign setup_ph = psel & ~penable;
	assign access_ph = psel & penable;

	assign sel_config = (paddr == lcd_pkg::addr_config);
	assign sel_cmd = (paddr == lcd_pkg::addr_cmd);
	assign sel_status = (paddr == lcd_pkg::addr_status);
	assign mapped = sel_config | sel_cmd | sel_status;

	// command write into a full queue is dropped
	assign overflow = pwrite & sel_cmd & full;

	assign pready = 1'b1;  // no wait states
	assign pslverr = access_ph & (~mapped | overflow);

	assign push = access_ph & pwrite & sel_cmd & ~full;
	assign push_cmd = lcd_pkg::lcd_cmd_t'(pwdata[9:0]);

	always_comb begin
		status.level = level;
		status.full = full;
		status.busy = busy;
		status.init_done = init_done;
	end

	// command address and unmapped space read as zero
	always_comb begin
		rd_mux = '0;
		if (sel_config) begin
			rd_mux[6:0] = cfg;
		end else if (sel_status) begin
			rd_mux[5:0] = status;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= lcd_pkg::lcd_cfg_t'(7'b0111000);
		end else if (access_ph && pwrite && sel_config) begin
			cfg <= lcd_pkg::lcd_cfg_t'(pwdata[6:0]);
		end
	end

	// loaded in the setup phase so data is valid during access
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prdata <= '0;
		end else if (setup_ph && !pwrite) begin
			prdata <= rd_mux;
		end else begin
			prdata <= '0;
		end
	end

endmodule

//--- verilog/lcd_hd44780_ctrl.sv
`timescale 1ns/1ps

module lcd_hd44780_ctrl (
	input logic clk,
	input logic rst_n,
	input lcd_pkg::lcd_cfg_t cfg,
	input logic empty,
	input lcd_pkg::lcd_cmd_t head,
	output logic pop,
	output logic busy,
	output logic init_done,
	output logic e,
	output logic rs,
	output logic rw,
	output logic [7:0] lcd_data
);

	typedef enum logic [1:0] {
		power_up,
		init,
		idle,
		send
	} state_t;

	typedef logic [lcd_pkg::cnt_bits-1:0] cnt_t;

	state_t state;
	cnt_t cnt;
	cnt_t cnt_next;
	logic [1:0] step;  // init step index
	logic in_gap;      // init step is in its e-low wait

	assign cnt_next = cnt + 1'b1;

	// init byte for each step, built from the current configuration
	function automatic logic [7:0] step_byte(input logic [1:0] idx, input lcd_pkg::lcd_cfg_t c);
		logic [7:0] b;
		case (idx)
			2'd0: b = {4'b0011, c.two_lines, c.font_5x10, 2'b00};       // function set
			2'd1: b = {5'b00001, c.display_on, c.cursor_on, c.blink_on}; // display control
			2'd2: b = 8'b0000_0001;                                      // clear
			default: b = {6'b000001, c.increment, c.shift};              // entry mode
		endcase
		return b;
	endfunction

	function automatic cnt_t gap_last(input logic [1:0] idx);
		return cnt_t'(lcd_pkg::init_gap_us[idx] * lcd_pkg::clk_per_us - 1);
	endfunction

	localparam cnt_t power_up_last = cnt_t'(lcd_pkg::power_up_us * lcd_pkg::clk_per_us - 1);
	localparam cnt_t init_pulse_last = cnt_t'(lcd_pkg::init_pulse_us * lcd_pkg::clk_per_us - 1);
	localparam cnt_t setup_cyc = cnt_t'(lcd_pkg::setup_us * lcd_pkg::clk_per_us);
	localparam cnt_t pulse_end = cnt_t'((lcd_pkg::setup_us + lcd_pkg::pulse_us)
		* lcd_pkg::clk_per_us);
	// the idle cycle that takes the next command closes the slot
	localparam cnt_t slot_last = cnt_t'(lcd_pkg::cycle_us * lcd_pkg::clk_per_us - 2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= power_up;
			cnt <= '0;
			step <= '0;
			in_gap <= 1'b0;
			pop <= 1'b0;
			busy <= 1'b1;
			init_done <= 1'b0;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			lcd_data <= '0;
		end else begin
			pop <= 1'b0;  // single-cycle strobe
			case (state)
				power_up: begin
					if (cnt == power_up_last) begin
						cnt <= '0;
						step <= 2'd0;
						in_gap <= 1'b0;
						e <= 1'b1;
						lcd_data <= step_byte(2'd0, cfg);
						state <= init;
					end else begin
						cnt <= cnt_next;
					end
				end
				init: begin
					if (!in_gap) begin
						if (cnt == init_pulse_last) begin  // end of e pulse
							cnt <= '0;
							in_gap <= 1'b1;
							e <= 1'b0;
							lcd_data <= '0;
						end else begin
							cnt <= cnt_next;
						end
					end else if (cnt == gap_last(step)) begin
						cnt <= '0;
						if (step == 2'd3) begin
							busy <= 1'b0;
							init_done <= 1'b1;
							state <= idle;
						end else begin
							step <= step + 2'd1;
							in_gap <= 1'b0;
							e <= 1'b1;
							lcd_data <= step_byte(step + 2'd1, cfg);
						end
					end else begin
						cnt <= cnt_next;
					end
				end
				idle: begin
					if (!empty) begin
						pop <= 1'b1;
						busy <= 1'b1;
						rs <= head.rs;
						rw <= head.rw;
						lcd_data <= head.data;
						cnt <= '0;
						state <= send;
					end
				end
				send: begin
					if (cnt == slot_last) begin
						busy <= 1'b0;
						e <= 1'b0;
						rs <= 1'b0;
						rw <= 1'b0;
						lcd_data <= '0;
						state <= idle;
					end else begin
						cnt <= cnt_next;
						e <= (cnt_next >= setup_cyc) && (cnt_next < pulse_end);
					end
				end
				default: state <= power_up;
			endcase
		end
	end

endmodule

//--- verilog/lcd_subsystem.sv
`timescale 1ns/1ps

module lcd_subsystem (
	input logic clk,
	input logic rst_n,
	input logic [3:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic e,
	output logic rs,
	output logic rw,
	output logic [7:0] lcd_data
);

	lcd_pkg::lcd_cfg_t cfg;
	lcd_pkg::lcd_cmd_t push_cmd;
	lcd_pkg::lcd_cmd_t head;
	logic push;
	logic pop;
	logic empty;
	logic full;
	logic busy;
	logic init_done;
	logic [lcd_pkg::fifo_level_bits-1:0] level;

	lcd_apb_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.cfg(cfg), .push(push), .push_cmd(push_cmd),
		.level(level), .full(full), .busy(busy), .init_done(init_done)
	);

	lcd_cmd_fifo u_fifo (
		.clk(clk), .rst_n(rst_n),
		.push(push), .push_cmd(push_cmd), .pop(pop),
		.head(head), .empty(empty), .full(full), .level(level)
	);

	lcd_hd44780_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.cfg(cfg), .empty(empty), .head(head), .pop(pop),
		.busy(busy), .init_done(init_done),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

endmodule

//--- verification/lcd_tb_vectors.svh
// one row per APB access, applied in order by lcd_tb
// columns: op, paddr, pwdata, expected prdata, expected pslverr, random data byte, slot spacing

localparam logic [1:0] op_write = 2'd0;
localparam logic [1:0] op_read = 2'd1;
localparam logic [1:0] op_wait = 2'd2;  // poll status until queue drained and not busy

localparam int num_vectors = 32;

typedef struct packed {
	logic [1:0] op;
	logic [3:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;  // expected read data
	logic err;           // expected pslverr
	logic rnd;           // low data byte comes from $random
	logic gap;           // pulse starts one slot after the previous one
} apb_row_t;

apb_row_t vectors [num_vectors];

task automatic load_vectors();
	vectors[0] = {op_read, 4'h8, 32'h0, 32'h02, 1'b0, 1'b0, 1'b0};    // busy during power-up
	vectors[1] = {op_write, 4'h0, 32'h1C, 32'h0, 1'b0, 1'b0, 1'b0};   // one line, cursor, blink
	vectors[2] = {op_read, 4'h0, 32'h0, 32'h1C, 1'b0, 1'b0, 1'b0};
	vectors[3] = {op_read, 4'h8, 32'h0, 32'h02, 1'b0, 1'b0, 1'b0};
	vectors[4] = {op_wait, 4'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0};     // through init
	vectors[5] = {op_read, 4'h8, 32'h0, 32'h01, 1'b0, 1'b0, 1'b0};
	vectors[6] = {op_write, 4'h4, 32'h080, 32'h0, 1'b0, 1'b0, 1'b0};  // set address
	vectors[7] = {op_write, 4'h4, 32'h248, 32'h0, 1'b0, 1'b0, 1'b1};  // data byte
	vectors[8] = {op_write, 4'h4, 32'h300, 32'h0, 1'b0, 1'b1, 1'b1};  // rs and rw high
	vectors[9] = {op_wait, 4'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0};
	vectors[10] = {op_read, 4'h8, 32'h0, 32'h01, 1'b0, 1'b0, 1'b0};
	vectors[11] = {op_write, 4'h4, 32'h0C0, 32'h0, 1'b0, 1'b0, 1'b0}; // keeps controller busy
	vectors[12] = {op_write, 4'h4, 32'h200, 32'h0, 1'b0, 1'b1, 1'b1};
	vectors[13] = {op_read, 4'h8, 32'h0, 32'h0B, 1'b0, 1'b0, 1'b0};   // level 1
	vectors[14] = {op_write, 4'h4, 32'h241, 32'h0, 1'b0, 1'b0, 1'b1};
	vectors[15] = {op_read, 4'h8, 32'h0, 32'h13, 1'b0, 1'b0, 1'b0};   // level 2
	vectors[16] = {op_write, 4'h4, 32'h300, 32'h0, 1'b0, 1'b1, 1'b1};
	vectors[17] = {op_read, 4'h8, 32'h0, 32'h1B, 1'b0, 1'b0, 1'b0};   // level 3
	vectors[18] = {op_write, 4'h4, 32'h200, 32'h0, 1'b0, 1'b1, 1'b1};
	vectors[19] = {op_read, 4'h8, 32'h0, 32'h27, 1'b0, 1'b0, 1'b0};   // level 4 and full
	vectors[20] = {op_write, 4'h4, 32'h2FF, 32'h0, 1'b1, 1'b0, 1'b0}; // dropped
	vectors[21] = {op_read, 4'h8, 32'h0, 32'h27, 1'b0, 1'b0, 1'b0};
	vectors[22] = {op_read, 4'h4, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0};    // command reads as zero
	vectors[23] = {op_wait, 4'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0};
	vectors[24] = {op_read, 4'h8, 32'h0, 32'h01, 1'b0, 1'b0, 1'b0};
	vectors[25] = {op_write, 4'h0, 32'h55, 32'h0, 1'b0, 1'b0, 1'b0};
	vectors[26] = {op_read, 4'h0, 32'h0, 32'h55, 1'b0, 1'b0, 1'b0};
	vectors[27] = {op_write, 4'h0, 32'hFFFF_FFFF, 32'h0, 1'b0, 1'b0, 1'b0};
	vectors[28] = {op_read, 4'h0, 32'h0, 32'h7F, 1'b0, 1'b0, 1'b0};   // only seven bits kept
	vectors[29] = {op_read, 4'hC, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0};    // unmapped
	vectors[30] = {op_write, 4'h2, 32'h1234, 32'h0, 1'b1, 1'b0, 1'b0};
	vectors[31] = {op_read, 4'h8, 32'h0, 32'h01, 1'b0, 1'b0, 1'b0};
endtask

//--- verification/lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb;

	localparam int clk_period_ns = 10;

	typedef struct packed {
		logic rs;
		logic rw;
		logic [7:0] data;
		logic [15:0] width;  // e high time in cycles
		logic gap;           // start spacing is checked
	} xfer_t;

	logic clk;
	logic rst_n;
	logic [3:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic e;
	logic rs;
	logic rw;
	logic [7:0] lcd_data;

	xfer_t expect_q [$];
	xfer_t cur;
	int errors = 0;
	int cycle_no = 0;
	int last_rise = 0;
	int high_cycles = 0;
	logic e_prev = 1'b0;
	integer seed;

	`include "lcd_tb_vectors.svh"

	lcd_subsystem UUT (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

	always #(clk_period_ns / 2) clk = ~clk;

	task automatic stop_on_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			errors = errors + 1;
			$display("[ERROR] time %0t %s got 0x%0h expected 0x%0h", $time, name, got, expected);
			stop_on_failure();
		end
	endtask

	task automatic expect_transfer(input logic t_rs, input logic t_rw, input logic [7:0] t_data,
			input int t_width, input logic t_gap);
		xfer_t x;
		x.rs = t_rs;
		x.rw = t_rw;
		x.data = t_data;
		x.width = t_width[15:0];
		x.gap = t_gap;
		expect_q.push_back(x);
	endtask

	// c holds two_lines font_5x10 display_on cursor_on blink_on increment shift from the top
	task automatic expect_init_sequence(input logic [6:0] c);
		int w;
		w = lcd_pkg::init_pulse_us * lcd_pkg::clk_per_us;
		expect_transfer(1'b0, 1'b0, {4'b0011, c[6], c[5], 2'b00}, w, 1'b0);
		expect_transfer(1'b0, 1'b0, {5'b00001, c[4], c[3], c[2]}, w, 1'b0);
		expect_transfer(1'b0, 1'b0, 8'h01, w, 1'b0);
		expect_transfer(1'b0, 1'b0, {6'b000001, c[1], c[0]}, w, 1'b0);
	endtask

	// one setup and one access phase with outputs sampled mid access
	task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		check_value("pready", pready, 1'b1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// level sits in status bits 5:3 and busy in bit 1
	task automatic wait_until_idle();
		logic [31:0] rd;
		logic err;
		do begin
			apb_access(1'b0, lcd_pkg::addr_status, 32'h0, rd, err);
			check_value("status pslverr", err, 1'b0);
		end while (rd[1] || (rd[5:3] != 3'd0));
	endtask

	// pin monitor sampling away from the rising edge
	always @(negedge clk) begin
		logic rising;
		logic falling;
		rising = e && !e_prev;
		falling = !e && e_prev;
		e_prev = e;
		cycle_no = cycle_no + 1;
		if (rising) begin
			if (expect_q.size() == 0) begin
				$display("an enable pulse appeared on the LCD bus with no transfer expected");
				stop_on_failure();
			end else begin
				cur = expect_q.pop_front();
				if (cur.gap) begin
					check_value("pulse_spacing", cycle_no - last_rise,
						lcd_pkg::cycle_us * lcd_pkg::clk_per_us);
				end
				last_rise = cycle_no;
				high_cycles = 1;
				check_value("rs", rs, cur.rs);
				check_value("rw", rw, cur.rw);
				check_value("lcd_data", lcd_data, cur.data);
			end
		end else if (e) begin
			high_cycles = high_cycles + 1;
			check_value("rs", rs, cur.rs);  // held through the pulse
			check_value("rw", rw, cur.rw);
			check_value("lcd_data", lcd_data, cur.data);
		end else if (falling) begin
			check_value("e_width", high_cycles, cur.width);
		end
	end

	initial begin : watchdog
		int limit_us;
		int k;
		limit_us = lcd_pkg::power_up_us + 60 * num_vectors + 200;  // 200 us margin
		for (k = 0; k < 4; k++) begin
			limit_us = limit_us + lcd_pkg::init_pulse_us + lcd_pkg::init_gap_us[k];
		end
		#(longint'(limit_us) * lcd_pkg::clk_per_us * clk_period_ns);
		$display("timeout: the LCD transfers did not finish in time");
		stop_on_failure();
	end

	initial begin : main_seq
		apb_row_t row;
		logic [31:0] wdata;
		logic [31:0] rd;
		logic [31:0] rnd_word;
		logic [6:0] cfg_model;
		logic err;
		logic init_queued;
		int i;
		clk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 4'h0;
		pwdata = 32'h0;
		seed = 47224;
		cfg_model = 7'b0111000;  // reset value
		init_queued = 1'b0;
		load_vectors();
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_value("e", e, 1'b0);
		check_value("rs", rs, 1'b0);
		check_value("rw", rw, 1'b0);
		check_value("lcd_data", lcd_data, 8'h00);
		check_value("pslverr", pslverr, 1'b0);
		check_value("prdata", prdata, 32'h0);
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("e", e, 1'b0);
		check_value("rs", rs, 1'b0);
		check_value("rw", rw, 1'b0);
		check_value("lcd_data", lcd_data, 8'h00);
		check_value("pslverr", pslverr, 1'b0);
		check_value("prdata", prdata, 32'h0);
		for (i = 0; i < num_vectors; i++) begin
			row = vectors[i];
			wdata = row.wdata;
			if (row.rnd) begin
				rnd_word = $random(seed);
				wdata[7:0] = rnd_word[7:0];
			end
			case (row.op)
				op_write: begin
					apb_access(1'b1, row.addr, wdata, rd, err);
					check_value($sformatf("row %0d pslverr", i), err, row.err);
					if (row.addr == lcd_pkg::addr_cmd && !row.err) begin
						expect_transfer(wdata[9], wdata[8], wdata[7:0],
							lcd_pkg::pulse_us * lcd_pkg::clk_per_us, row.gap);
					end
					if (row.addr == lcd_pkg::addr_config && !row.err) begin
						cfg_model = wdata[6:0];
					end
				end
				op_read: begin
					apb_access(1'b0, row.addr, 32'h0, rd, err);
					check_value($sformatf("row %0d pslverr", i), err, row.err);
					check_value($sformatf("row %0d prdata", i), rd, row.rdata);
				end
				default: begin
					if (!init_queued) begin
						expect_init_sequence(cfg_model);
						init_queued = 1'b1;
					end
					wait_until_idle();
				end
			endcase
		end
		check_value("pending_transfers", expect_q.size(), 0);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
verilog/lcd_pkg.sv
verilog/lcd_cmd_fifo.sv
verilog/lcd_apb_regs.sv
verilog/lcd_hd44780_ctrl.sv
verilog/lcd_subsystem.sv
+incdir+verification
verification/lcd_tb.sv
